// File: project.f
common/xbar_pkg.sv
master_port/txn_counter.sv
master_port/master_port.sv
arbiter/grant_arbiter.sv
verilog/slave_port.sv
verilog/wb_xbar.sv
testbench/wb_slave_model.sv
testbench/wb_xbar_tb.sv

// File: run.sh
#!/bin/bash
# compile with Verilator and run; pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module wb_xbar_tb -o wb_xbar_sim &&
./obj_dir/wb_xbar_sim | tee /dev/stderr | grep -q "No errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/wb_xbar_tb.sv
`timescale 1ns/1ps

module wb_xbar_tb
	import xbar_pkg::*;
;
	localparam int TIMEOUT_CYCLES = 200;

	logic                  clk;
	logic                  arst_n;
	logic [NM-1:0]         mcyc;
	logic [NM-1:0]         mstb;
	logic [NM-1:0]         mwe;
	logic [NM-1:0][AW-1:0] maddr;
	logic [NM-1:0][DW-1:0] mdata;
	logic [NM-1:0][SW-1:0] msel;
	logic [NM-1:0]         o_mstall;
	logic [NM-1:0]         o_mack;
	logic [NM-1:0]         o_merr;
	logic [NM-1:0][DW-1:0] o_mdata;
	logic [NS-1:0]         o_scyc;
	logic [NS-1:0]         o_sstb;
	logic [NS-1:0]         o_swe;
	logic [NS-1:0][AW-1:0] o_saddr;
	logic [NS-1:0][DW-1:0] o_sdata;
	logic [NS-1:0][SW-1:0] o_ssel;
	logic [NS-1:0]         sstall;
	logic [NS-1:0]         sack;
	logic [NS-1:0]         serr;
	logic [NS-1:0][DW-1:0] sdata;
	logic [NS-1:0]         rnd_stall;
	logic [NS-1:0]         rnd_ack;
	logic                  rnd_en;
	logic [31:0]           lfsr;
	logic [DW-1:0]         shadow [NS][16];

	wb_xbar wb_xbar_inst (
		.i_clk (clk), .i_arst_n (arst_n),
		.i_mcyc (mcyc), .i_mstb (mstb), .i_mwe (mwe),
		.i_maddr (maddr), .i_mdata (mdata), .i_msel (msel),
		.o_mstall (o_mstall), .o_mack (o_mack), .o_merr (o_merr), .o_mdata (o_mdata),
		.o_scyc (o_scyc), .o_sstb (o_sstb), .o_swe (o_swe),
		.o_saddr (o_saddr), .o_sdata (o_sdata), .o_ssel (o_ssel),
		.i_sstall (sstall), .i_sack (sack), .i_serr (serr), .i_sdata (sdata)
	);

	for (genvar s = 0; s < NS; s++)
	begin : g_model
		wb_slave_model #(.SLAVE_ID (s)) slave_inst (
			.i_clk (clk), .i_arst_n (arst_n),
			.i_cyc (o_scyc[s]), .i_stb (o_sstb[s]), .i_we (o_swe[s]),
			.i_addr (o_saddr[s]), .i_data (o_sdata[s]), .i_sel (o_ssel[s]),
			.i_rnd_stall (rnd_stall[s]), .i_rnd_ack (rnd_ack[s]),
			.o_stall (sstall[s]), .o_ack (sack[s]), .o_data (sdata[s])
		);
	end

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// galois form, one step per bit
	function automatic logic lfsr_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	always @(posedge clk)
	begin
		for (int s = 0; s < NS; s++)
		begin
			if (rnd_en)
			begin
				rnd_stall[s] <= lfsr_bit();
				rnd_ack[s]   <= lfsr_bit();
			end
			else
			begin
				rnd_stall[s] <= 1'b0;
				rnd_ack[s]   <= 1'b1;
			end
		end
	end

	task automatic fail_now();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic fail_timeout(input string what);
		$display("timed out waiting for %s", what);
		fail_now();
	endtask

	task automatic compare_data(input string name, input logic [DW-1:0] act,
		input logic [DW-1:0] exp);
		if (act !== exp)
		begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, act, exp);
			fail_now();
		end
	endtask

	task automatic compare_addr(input string name, input logic [AW-1:0] act,
		input logic [AW-1:0] exp);
		if (act !== exp)
		begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, act, exp);
			fail_now();
		end
	endtask

	task automatic compare_flag(input string name, input logic act, input logic exp);
		if (act !== exp)
		begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, act, exp);
			fail_now();
		end
	endtask

	task automatic compare_chan(input string name, input chan_state_t act,
		input chan_state_t exp);
		if (act !== exp)
		begin
			$display("ERROR at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
			fail_now();
		end
	endtask

	task automatic check_count(input string name, input int act, input int limit);
		if (act > limit)
		begin
			$display("ERROR at %0t: %s is %0d, expected at most %0d", $time, name, act, limit);
			fail_now();
		end
	endtask

	function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
		input logic [DW-1:0] nw, input logic [SW-1:0] sel);
		logic [DW-1:0] r;
		r = old;
		for (int b = 0; b < SW; b++)
			if (sel[b])
				r[8*b +: 8] = nw[8*b +: 8];
		return r;
	endfunction

	// n requests on consecutive words, acks checked in order
	task automatic master_burst(input int m, input int n, input logic we,
		input logic [AW-1:0] addr, input logic [SW-1:0] sel, input logic [DW-1:0] wbase);
		logic [DW-1:0] exp_q [$];
		logic          chk_q [$];
		logic [AW-1:0] a;
		logic          accepted;
		int            sent;
		int            got;
		int            cycles;
		sent = 0;
		got = 0;
		cycles = 0;
		@(posedge clk);
		mcyc[m]  <= 1'b1;
		mstb[m]  <= 1'b1;
		mwe[m]   <= we;
		maddr[m] <= addr;
		mdata[m] <= wbase;
		msel[m]  <= sel;
		while (got < n)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				fail_timeout("master burst acks");
			compare_flag("o_merr", o_merr[m], 1'b0);
			check_count("outstanding", sent - got, 7);
			if (o_mack[m])
			begin
				if (exp_q.size() == 0)
				begin
					$display("ack arrived with nothing outstanding on master %0d", m);
					fail_now();
				end
				if (chk_q.pop_front())
					compare_data("o_mdata", o_mdata[m], exp_q.pop_front());
				else
					void'(exp_q.pop_front());
				got++;
			end
			accepted = mstb[m] && !o_mstall[m];
			@(posedge clk);
			if (accepted)
			begin
				a = addr + AW'(sent);
				// mapped slaves differ in address bit 14
				if (we)
					shadow[a[14]][a[3:0]] = merge_bytes(shadow[a[14]][a[3:0]],
						wbase + sent * 32'h0101_0101, sel);
				exp_q.push_back(shadow[a[14]][a[3:0]]);
				chk_q.push_back(!we);
				sent++;
				if (sent < n)
				begin
					maddr[m] <= addr + AW'(sent);
					mdata[m] <= wbase + sent * 32'h0101_0101;
				end
				else
					mstb[m] <= 1'b0;
			end
		end
		@(posedge clk);
		mcyc[m] <= 1'b0;
	endtask

	task automatic first_strobe_addr(input int s, input logic [AW-1:0] exp);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!o_sstb[s])
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				fail_timeout("first slave strobe");
			@(negedge clk);
		end
		compare_addr("o_saddr", o_saddr[s], exp);
	endtask

	task automatic check_reset_state();
		for (int m = 0; m < NM; m++)
		begin
			compare_flag($sformatf("o_mstall[%0d]", m), o_mstall[m], 1'b1);
			compare_flag($sformatf("o_mack[%0d]", m), o_mack[m], 1'b0);
			compare_flag($sformatf("o_merr[%0d]", m), o_merr[m], 1'b0);
			compare_chan($sformatf("chan[%0d]", m), wb_xbar_inst.chan[m], CHAN_IDLE);
		end
		compare_flag("o_scyc", |o_scyc, 1'b0);
		compare_flag("o_sstb", |o_sstb, 1'b0);
	endtask

	task automatic test_write_read();
		master_burst(0, 1, 1'b1, 16'h0001, 4'b0101, 32'h1122_3344);
		master_burst(0, 1, 1'b0, 16'h0001, 4'hf, '0);
		master_burst(0, 1, 1'b1, 16'h4004, 4'hf, 32'hdead_beef);
		master_burst(0, 1, 1'b0, 16'h4004, 4'hf, '0);
	endtask

	task automatic test_unmapped();
		int cycles;
		cycles = 0;
		@(posedge clk);
		mcyc[0]  <= 1'b1;
		mstb[0]  <= 1'b1;
		mwe[0]   <= 1'b0;
		maddr[0] <= 16'h8000;
		@(negedge clk);
		while (!o_merr[0])
		begin
			compare_flag("o_mack", o_mack[0], 1'b0);
			compare_flag("o_sstb", |o_sstb, 1'b0);
			compare_flag("o_scyc", |o_scyc, 1'b0);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				fail_timeout("bus error");
			@(negedge clk);
		end
		compare_flag("o_mack", o_mack[0], 1'b0);
		compare_flag("o_mstall", o_mstall[0], 1'b0);
		compare_flag("o_scyc", |o_scyc, 1'b0);
		compare_chan("chan[0]", wb_xbar_inst.chan[0], CHAN_ERROR);
		@(posedge clk);
		mcyc[0] <= 1'b0;
		mstb[0] <= 1'b0;
		@(negedge clk);
		compare_flag("o_sstb", |o_sstb, 1'b0);
		compare_flag("o_merr", o_merr[0], 1'b0);
	endtask

	task automatic test_contention();
		fork
			master_burst(0, 1, 1'b1, 16'h0002, 4'hf, 32'hcafe_0000);
			master_burst(1, 1, 1'b1, 16'h0003, 4'hf, 32'hbeef_0000);
			first_strobe_addr(0, 16'h0002);
		join
		fork
			master_burst(0, 1, 1'b0, 16'h0002, 4'hf, '0);
			master_burst(1, 1, 1'b0, 16'h0003, 4'hf, '0);
		join
	endtask

	task automatic test_parallel();
		fork
			master_burst(0, 3, 1'b1, 16'h0008, 4'hf, 32'h0a0a_0000);
			master_burst(1, 3, 1'b1, 16'h4008, 4'hf, 32'h0b0b_0000);
		join
		fork
			master_burst(0, 3, 1'b0, 16'h0008, 4'hf, '0);
			master_burst(1, 3, 1'b0, 16'h4008, 4'hf, '0);
		join
	endtask

	task automatic test_random_burst();
		@(posedge clk);
		rnd_en <= 1'b1;
		master_burst(0, 10, 1'b0, 16'h0000, 4'hf, '0);
		@(posedge clk);
		rnd_en <= 1'b0;
	endtask

	task automatic test_cycle_drop();
		int cycles;
		cycles = 0;
		@(posedge clk);
		mcyc[0]  <= 1'b1;
		mstb[0]  <= 1'b1;
		mwe[0]   <= 1'b0;
		maddr[0] <= 16'h4005;
		@(negedge clk);
		while (o_mstall[0])
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				fail_timeout("grant of slave 1 to master 0");
			@(negedge clk);
		end
		fork
			begin
				@(posedge clk);
				mstb[0] <= 1'b0;
				@(posedge clk);
				mcyc[0] <= 1'b0;
			end
			master_burst(1, 2, 1'b1, 16'h4006, 4'b1100, 32'h7788_99aa);
		join
		master_burst(1, 2, 1'b0, 16'h4006, 4'hf, '0);
	endtask

	initial
	begin
		arst_n    = 1'b0;
		mcyc      = '0;
		mstb      = '0;
		mwe       = '0;
		maddr     = '0;
		mdata     = '0;
		msel      = '0;
		serr      = '0;
		rnd_stall = '0;
		rnd_ack   = '1;
		rnd_en    = 1'b0;
		lfsr      = 32'hc937;
		for (int s = 0; s < NS; s++)
			for (int i = 0; i < 16; i++)
				shadow[s][i] = 32'h5a00_0000 | (32'(s) << 16) | (32'(i) * 32'h111);
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_reset_state();
		test_write_read();
		test_unmapped();
		test_contention();
		test_parallel();
		test_random_burst();
		test_cycle_drop();
		repeat (2) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule

// File: testbench/wb_slave_model.sv
`timescale 1ns/1ps

module wb_slave_model
	import xbar_pkg::*;
#(
	parameter int SLAVE_ID = 0
)
(
	input  logic          i_clk,
	input  logic          i_arst_n,
	input  logic          i_cyc,
	input  logic          i_stb,
	input  logic          i_we,
	input  logic [AW-1:0] i_addr,
	input  logic [DW-1:0] i_data,
	input  logic [SW-1:0] i_sel,
	input  logic          i_rnd_stall,
	input  logic          i_rnd_ack,
	output logic          o_stall,
	output logic          o_ack,
	output logic [DW-1:0] o_data
);
	logic [DW-1:0] mem [16];
	logic [DW-1:0] resp_q [$];

	// stall straight from the random source
	assign o_stall = i_rnd_stall;

	always @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < 16; i++)
				mem[i] = 32'h5a00_0000 | (32'(SLAVE_ID) << 16) | (32'(i) * 32'h111);
			resp_q.delete();
			o_ack  <= 1'b0;
			o_data <= '0;
		end
		else if (!i_cyc)
		begin
			// abandoned requests are forgotten
			resp_q.delete();
			o_ack <= 1'b0;
		end
		else
		begin
			o_ack <= 1'b0;
			if (resp_q.size() > 0 && i_rnd_ack)
			begin
				o_ack  <= 1'b1;
				o_data <= resp_q.pop_front();
			end
			if (i_stb && !o_stall)
			begin
				if (i_we)
				begin
					for (int b = 0; b < SW; b++)
						if (i_sel[b])
							mem[i_addr[3:0]][8*b +: 8] = i_data[8*b +: 8];
				end
				resp_q.push_back(mem[i_addr[3:0]]);
			end
		end
	end

endmodule

// File: verilog/wb_xbar.sv
`timescale 1ns/1ps

module wb_xbar
	import xbar_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic [NM-1:0]         i_mcyc,
	input  logic [NM-1:0]         i_mstb,
	input  logic [NM-1:0]         i_mwe,
	input  logic [NM-1:0][AW-1:0] i_maddr,
	input  logic [NM-1:0][DW-1:0] i_mdata,
	input  logic [NM-1:0][SW-1:0] i_msel,
	output logic [NM-1:0]         o_mstall,
	output logic [NM-1:0]         o_mack,
	output logic [NM-1:0]         o_merr,
	output logic [NM-1:0][DW-1:0] o_mdata,
	output logic [NS-1:0]         o_scyc,
	output logic [NS-1:0]         o_sstb,
	output logic [NS-1:0]         o_swe,
	output logic [NS-1:0][AW-1:0] o_saddr,
	output logic [NS-1:0][DW-1:0] o_sdata,
	output logic [NS-1:0][SW-1:0] o_ssel,
	input  logic [NS-1:0]         i_sstall,
	input  logic [NS-1:0]         i_sack,
	input  logic [NS-1:0]         i_serr,
	input  logic [NS-1:0][DW-1:0] i_sdata
);
	logic [NM-1:0][NS-1:0]     req;
	logic [NS-1:0][NM-1:0]     req_hit_t;
	logic [NM-1:0]             req_none;
	logic [NM-1:0]             req_stb;
	logic [NM-1:0]             req_we;
	logic [NM-1:0][AW-1:0]     req_addr;
	logic [NM-1:0][DW-1:0]     req_data;
	logic [NM-1:0][SW-1:0]     req_sel;
	logic [NM-1:0]             pend_empty;
	chan_state_t [NM-1:0]      chan;
	logic [NM-1:0][SIDX_W-1:0] mindex;
	logic [NS-1:0]             sgrant;
	logic [NS-1:0][MIDX_W-1:0] sindex;
	logic [NS-1:0]             s_stall;
	logic [NS-1:0]             s_ack;
	logic [NS-1:0]             s_err;
	logic [NS-1:0][DW-1:0]     s_data;

	for (genvar m = 0; m < NM; m++)
	begin : g_master
		master_port master_port_inst (
			.i_clk        (i_clk),
			.i_arst_n     (i_arst_n),
			.i_mcyc       (i_mcyc[m]),
			.i_mstb       (i_mstb[m]),
			.i_mwe        (i_mwe[m]),
			.i_maddr      (i_maddr[m]),
			.i_mdata      (i_mdata[m]),
			.i_msel       (i_msel[m]),
			.i_chan       (chan[m]),
			.i_mindex     (mindex[m]),
			.i_s_stall    (s_stall),
			.i_s_ack      (s_ack),
			.i_s_err      (s_err),
			.i_s_data     (s_data),
			.o_req        (req[m]),
			.o_req_none   (req_none[m]),
			.o_req_stb    (req_stb[m]),
			.o_req_we     (req_we[m]),
			.o_req_addr   (req_addr[m]),
			.o_req_data   (req_data[m]),
			.o_req_sel    (req_sel[m]),
			.o_pend_empty (pend_empty[m]),
			.o_mstall     (o_mstall[m]),
			.o_mack       (o_mack[m]),
			.o_merr       (o_merr[m]),
			.o_mdata      (o_mdata[m])
		);
	end

	grant_arbiter grant_arbiter_inst (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_mcyc       (i_mcyc),
		.i_req        (req),
		.i_req_none   (req_none),
		.i_pend_empty (pend_empty),
		.o_chan       (chan),
		.o_mindex     (mindex),
		.o_sgrant     (sgrant),
		.o_sindex     (sindex)
	);

	for (genvar s = 0; s < NS; s++)
	begin : g_slave
		// request bits regrouped per slave
		for (genvar m = 0; m < NM; m++)
		begin : g_hit
			assign req_hit_t[s][m] = req[m][s];
		end

		slave_port slave_port_inst (
			.i_clk      (i_clk),
			.i_arst_n   (i_arst_n),
			.i_sgrant   (sgrant[s]),
			.i_sindex   (sindex[s]),
			.i_mcyc     (i_mcyc),
			.i_req_stb  (req_stb),
			.i_req_hit  (req_hit_t[s]),
			.i_req_we   (req_we),
			.i_req_addr (req_addr),
			.i_req_data (req_data),
			.i_req_sel  (req_sel),
			.i_sstall   (i_sstall[s]),
			.i_sack     (i_sack[s]),
			.i_serr     (i_serr[s]),
			.i_sdata    (i_sdata[s]),
			.o_scyc     (o_scyc[s]),
			.o_sstb     (o_sstb[s]),
			.o_swe      (o_swe[s]),
			.o_saddr    (o_saddr[s]),
			.o_sdata    (o_sdata[s]),
			.o_ssel     (o_ssel[s]),
			.o_s_stall  (s_stall[s]),
			.o_s_ack    (s_ack[s]),
			.o_s_err    (s_err[s]),
			.o_s_data   (s_data[s])
		);
	end

endmodule

// File: verilog/slave_port.sv
`timescale 1ns/1ps

module slave_port
	import xbar_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_sgrant,
	input  logic [MIDX_W-1:0]     i_sindex,
	input  logic [NM-1:0]         i_mcyc,
	input  logic [NM-1:0]         i_req_stb,
	input  logic [NM-1:0]         i_req_hit,
	input  logic [NM-1:0]         i_req_we,
	input  logic [NM-1:0][AW-1:0] i_req_addr,
	input  logic [NM-1:0][DW-1:0] i_req_data,
	input  logic [NM-1:0][SW-1:0] i_req_sel,
	input  logic                  i_sstall,
	input  logic                  i_sack,
	input  logic                  i_serr,
	input  logic [DW-1:0]         i_sdata,
	output logic                  o_scyc,
	output logic                  o_sstb,
	output logic                  o_swe,
	output logic [AW-1:0]         o_saddr,
	output logic [DW-1:0]         o_sdata,
	output logic [SW-1:0]         o_ssel,
	output logic                  o_s_stall,
	output logic                  o_s_ack,
	output logic                  o_s_err,
	output logic [DW-1:0]         o_s_data
);
	logic owner_cyc;
	logic owner_stb;

	assign owner_cyc = i_mcyc[i_sindex];
	assign owner_stb = i_req_stb[i_sindex] && i_req_hit[i_sindex];

	// raw slave responses only count inside our own cycle
	assign o_s_stall = o_sstb && i_sstall;
	assign o_s_ack   = o_scyc && i_sack;
	assign o_s_err   = o_scyc && i_serr;
	assign o_s_data  = i_sdata;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_scyc <= 1'b0;
			o_sstb <= 1'b0;
		end
		else if (!i_sgrant || !owner_cyc || o_s_err)
		begin
			o_scyc <= 1'b0;
			o_sstb <= 1'b0;
		end
		else
		begin
			o_scyc <= 1'b1;
			if (!o_s_stall)
				o_sstb <= owner_stb;
		end
	end

	// request fields hold while the slave stalls
	always_ff @(posedge i_clk)
	begin
		if (i_sgrant && !o_s_stall)
		begin
			o_swe   <= i_req_we[i_sindex];
			o_saddr <= i_req_addr[i_sindex];
			o_sdata <= i_req_data[i_sindex];
			o_ssel  <= i_req_sel[i_sindex];
		end
	end

	a_stb_in_cyc : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_sstb |-> o_scyc);

endmodule

// File: arbiter/grant_arbiter.sv
`timescale 1ns/1ps

module grant_arbiter
	import xbar_pkg::*;
(
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	input  logic [NM-1:0]             i_mcyc,
	input  logic [NM-1:0][NS-1:0]     i_req,
	input  logic [NM-1:0]             i_req_none,
	input  logic [NM-1:0]             i_pend_empty,
	output chan_state_t [NM-1:0]      o_chan,
	output logic [NM-1:0][SIDX_W-1:0] o_mindex,
	output logic [NS-1:0]             o_sgrant,
	output logic [NS-1:0][MIDX_W-1:0] o_sindex
);
	chan_state_t [NM-1:0]      chan_nxt;
	logic [NM-1:0][SIDX_W-1:0] mindex_nxt;
	logic [NM-1:0]             keep;
	logic [NS-1:0]             held;
	logic [NS-1:0][NM-1:0]     owner;

	always_comb
	begin
		held = '0;
		// busy masters, or masters still after the same slave, keep it
		for (int m = 0; m < NM; m++)
		begin
			keep[m] = 1'b0;
			if (i_mcyc[m] && o_chan[m] == CHAN_SLAVE)
			begin
				keep[m] = !i_pend_empty[m] || !(|i_req[m] || i_req_none[m]);
				for (int s = 0; s < NS; s++)
				begin
					if (o_mindex[m] == SIDX_W'(s))
					begin
						keep[m] = keep[m] || i_req[m][s];
						held[s] = held[s] || keep[m];
					end
				end
			end
		end

		// free slaves go to the lowest numbered requester
		for (int m = 0; m < NM; m++)
		begin
			chan_nxt[m]   = CHAN_IDLE;
			mindex_nxt[m] = SIDX_W'(NS);
			if (keep[m])
			begin
				chan_nxt[m]   = CHAN_SLAVE;
				mindex_nxt[m] = o_mindex[m];
			end
			else if (i_mcyc[m] && i_req_none[m])
				chan_nxt[m] = CHAN_ERROR;
			else if (i_mcyc[m])
			begin
				for (int s = 0; s < NS; s++)
				begin
					if (i_req[m][s] && !held[s])
					begin
						chan_nxt[m]   = CHAN_SLAVE;
						mindex_nxt[m] = SIDX_W'(s);
						held[s]       = 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int m = 0; m < NM; m++)
			begin
				o_chan[m]   <= CHAN_IDLE;
				o_mindex[m] <= SIDX_W'(NS);
			end
		end
		else
		begin
			o_chan   <= chan_nxt;
			o_mindex <= mindex_nxt;
		end
	end

	// slave side view of the same grants
	always_comb
	begin
		o_sgrant = '0;
		o_sindex = '0;
		for (int s = 0; s < NS; s++)
		begin
			for (int m = 0; m < NM; m++)
			begin
				owner[s][m] = (o_chan[m] == CHAN_SLAVE) && (o_mindex[m] == SIDX_W'(s));
				if (owner[s][m])
				begin
					o_sgrant[s] = 1'b1;
					o_sindex[s] = MIDX_W'(m);
				end
			end
		end
	end

	for (genvar s = 0; s < NS; s++)
	begin : g_owner_check
		a_single_owner : assert property (@(posedge i_clk) disable iff (!i_arst_n)
			$onehot0(owner[s]));
	end

endmodule

// File: master_port/master_port.sv
`timescale 1ns/1ps

module master_port
	import xbar_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_mcyc,
	input  logic                  i_mstb,
	input  logic                  i_mwe,
	input  logic [AW-1:0]         i_maddr,
	input  logic [DW-1:0]         i_mdata,
	input  logic [SW-1:0]         i_msel,
	input  chan_state_t           i_chan,
	input  logic [SIDX_W-1:0]     i_mindex,
	input  logic [NS-1:0]         i_s_stall,
	input  logic [NS-1:0]         i_s_ack,
	input  logic [NS-1:0]         i_s_err,
	input  logic [NS-1:0][DW-1:0] i_s_data,
	output logic [NS-1:0]         o_req,
	output logic                  o_req_none,
	output logic                  o_req_stb,
	output logic                  o_req_we,
	output logic [AW-1:0]         o_req_addr,
	output logic [DW-1:0]         o_req_data,
	output logic [SW-1:0]         o_req_sel,
	output logic                  o_pend_empty,
	output logic                  o_mstall,
	output logic                  o_mack,
	output logic                  o_merr,
	output logic [DW-1:0]         o_mdata
);
	logic [NS-1:0] hit;
	logic          near_full;
	logic          accept;
	logic          held_hit;
	logic          slv_stall;
	logic          slv_ack;
	logic          slv_err;
	logic [DW-1:0] slv_data;

	// address decode against the fixed map
	always_comb
	begin
		for (int s = 0; s < NS; s++)
			hit[s] = ((i_maddr ^ SLAVE_BASE[s]) & SLAVE_MASK[s]) == '0;
	end

	// no new strobes once near full
	assign o_req_stb  = i_mcyc && i_mstb && !near_full;
	assign o_req      = hit & {NS{o_req_stb}};
	assign o_req_none = o_req_stb && !(|hit);
	assign o_req_we   = i_mwe;
	assign o_req_addr = i_maddr;
	assign o_req_data = i_mdata;
	assign o_req_sel  = i_msel;

	// response of the slave this master holds
	always_comb
	begin
		held_hit  = 1'b0;
		slv_stall = 1'b1;
		slv_ack   = 1'b0;
		slv_err   = 1'b0;
		slv_data  = '0;
		for (int s = 0; s < NS; s++)
		begin
			if (i_mindex == SIDX_W'(s))
			begin
				held_hit  = hit[s];
				slv_stall = i_s_stall[s];
				slv_ack   = i_s_ack[s];
				slv_err   = i_s_err[s];
				slv_data  = i_s_data[s];
			end
		end
	end

	always_comb
	begin
		o_mdata = slv_data;
		case (i_chan)
			CHAN_SLAVE:
			begin
				// a request for another slave waits for a regrant
				o_mstall = slv_stall || near_full || (i_mstb && !held_hit);
				o_mack   = i_mcyc && slv_ack;
				o_merr   = i_mcyc && slv_err;
			end
			CHAN_ERROR:
			begin
				o_mstall = 1'b0;
				o_mack   = 1'b0;
				o_merr   = i_mcyc;
			end
			default:
			begin
				o_mstall = 1'b1;
				o_mack   = 1'b0;
				o_merr   = 1'b0;
			end
		endcase
	end

	assign accept = i_mcyc && i_mstb && !o_mstall;

	txn_counter txn_counter_inst (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_mcyc      (i_mcyc),
		.i_accept    (accept),
		.i_ack       (o_mack),
		.i_err       (o_merr),
		.o_empty     (o_pend_empty),
		.o_near_full (near_full)
	);

endmodule

// File: master_port/txn_counter.sv
`timescale 1ns/1ps

module txn_counter
	import xbar_pkg::*;
(
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_mcyc,
	input  logic i_accept,
	input  logic i_ack,
	input  logic i_err,
	output logic o_empty,
	output logic o_near_full
);
	logic [LG_MAX_PENDING-1:0] count;
	logic [LG_MAX_PENDING-1:0] count_nxt;

	always_comb
	begin
		count_nxt = count;
		if (i_accept && !i_ack)
			count_nxt = count + 1'b1;
		else if (!i_accept && i_ack)
			count_nxt = count - 1'b1;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			count       <= '0;
			o_empty     <= 1'b1;
			o_near_full <= 1'b0;
		end
		else if (!i_mcyc || i_err)
		begin
			// bus cycle over, nothing left in flight
			count       <= '0;
			o_empty     <= 1'b1;
			o_near_full <= 1'b0;
		end
		else
		begin
			count       <= count_nxt;
			o_empty     <= (count_nxt == '0);
			o_near_full <= (count_nxt >= PENDING_NEAR_FULL);
		end
	end

	// the near-full stall must keep the count from wrapping
	a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(count == PENDING_MAX) |-> !(i_accept && !i_ack));

endmodule

// File: common/xbar_pkg.sv
package xbar_pkg;

	// bus geometry
	localparam int NM = 2;
	localparam int NS = 2;
	localparam int AW = 16;
	localparam int DW = 32;
	localparam int SW = DW / 8;

	// slave 0 at 0x0000, slave 1 at 0x4000, decoded on the top two bits
	localparam logic [NS-1:0][AW-1:0] SLAVE_BASE = {16'h4000, 16'h0000};
	localparam logic [NS-1:0][AW-1:0] SLAVE_MASK = {16'hc000, 16'hc000};

	// outstanding transactions per master
	localparam int LG_MAX_PENDING = 3;
	localparam logic [LG_MAX_PENDING-1:0] PENDING_MAX = '1;
	localparam logic [LG_MAX_PENDING-1:0] PENDING_NEAR_FULL = PENDING_MAX - 1'b1;

	// index widths, slave index also holds the no-slave channel NS
	localparam int MIDX_W = (NM > 1) ? $clog2(NM) : 1;
	localparam int SIDX_W = $clog2(NS + 1);

	// what a master currently holds
	typedef enum logic [1:0]
	{
		CHAN_IDLE  = 2'd0,
		CHAN_SLAVE = 2'd1,
		CHAN_ERROR = 2'd2
	} chan_state_t;

endpackage
